//--- build.f
+incdir+verif
src/quplsDecodePkg.sv
src/decodeImm.sv
src/decodeRab.sv
src/decodeRc.sv
src/decodeRt.sv
src/decodeStage.sv
verif/decodeStageTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f build.f --top-module decodeStageTb -o decodeSim
output=$(./obj_dir/decodeSim)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "Test passed"; then
	exit 0
fi
exit 1

//--- src/decodeImm.sv
// Flags the Rb and Rc operand slots that hold an immediate
// immPostfix must be valid in the same cycle as instr because it is not registered
// Purely combinational with no clock

`timescale 1ns/10ps

module decodeImm import quplsDecodePkg::*;
(
	input instr_t instr,
	input logic immPostfix,
	output logic hasImmb,
	output logic hasImmc
);

always_comb
begin
	// Rb immediates come only from ADDI and the short-immediate group
	hasImmb = fnImmb(instr.opcode);

	// A postfix always supplies Rc
	// Without one the immc bit decides for opcodes of the default group
	hasImmc = immPostfix | fnImmc(instr);
end

endmodule

//--- src/decodeRab.sv
// Decodes the Ra and Rb source operands
// Register 31 becomes the stack pointer of mode om
// An immediate in the Rb slot reads as register 0 with no negate
// Purely combinational

`timescale 1ns/10ps

module decodeRab import quplsDecodePkg::*;
(
	input instr_t instr,
	input operating_mode_t om,
	input logic hasImmb,
	output regOperand_t Ra,
	output regOperand_t Rb
);

// Raw 5-bit selections before the stack-pointer remap
logic [4:0] rbSel;
logic rbNeg;

// ========================================
// Ra operand
// ========================================

// Ra has no immediate form, it always follows its own field
always_comb
begin
	Ra = fnMakeOperand(fnMapReg(instr.Ra.num, om), instr.Ra.n);
end

// ========================================
// Rb operand
// ========================================

always_comb
begin
	if (hasImmb)
	begin
		// The immediate value travels elsewhere, the slot reads as r0
		rbSel = 5'd0;
		rbNeg = 1'b0;
	end
	else
	begin
		rbSel = instr.Rb.num;
		rbNeg = instr.Rb.n;
	end

	// Mapping r0 is harmless, it passes straight through
	Rb = fnMakeOperand(fnMapReg(rbSel, om), rbNeg);
end

endmodule

//--- src/decodeRc.sv
// Decodes the Rc source operand
// For the short-immediate group and for stores Rc is read from the Rt field
// An immediate Rc slot reads as register 0 with no negate
// Purely combinational

`timescale 1ns/10ps

module decodeRc import quplsDecodePkg::*;
(
	input instr_t instr,
	input operating_mode_t om,
	input logic hasImmc,
	output regOperand_t Rc
);

// Field chosen for Rc before the stack-pointer remap
logic [4:0] rcSel;
logic rcNeg;

// ========================================
// Rc selection
// ========================================

always_comb
begin
	// Rules are applied in priority order, the immediate check wins
	if (hasImmc)
	begin
		rcSel = 5'd0;
		rcNeg = 1'b0;
	end
	else if (fnIsSiGroup(instr.opcode) || fnIsStore(instr.opcode))
	begin
		// Accumulate source for the SI group, store data for stores
		rcSel = instr.Rt.num;
		rcNeg = instr.Rt.n;
	end
	else
	begin
		// R2, SHIFT and every remaining opcode use the Rc field as is
		rcSel = instr.Rc.num;
		rcNeg = instr.Rc.n;
	end
end

// ========================================
// Remap and zero flag
// ========================================

// Stack-pointer remap applies after the field choice, so a store of r31
// writes out the mode's stack pointer
always_comb
begin
	Rc = fnMakeOperand(fnMapReg(rcSel, om), rcNeg);
end

endmodule

//--- src/decodeRt.sv
// Decodes the Rt destination operand
// Stores have no destination, their Rt field is consumed by decodeRc
// Purely combinational

`timescale 1ns/10ps

module decodeRt import quplsDecodePkg::*;
(
	input instr_t instr,
	input operating_mode_t om,
	output regOperand_t Rt
);

// Destination field before the stack-pointer remap
logic [4:0] rtSel;
logic rtNeg;

always_comb
begin
	if (fnIsStore(instr.opcode))
	begin
		// Writing r0 is discarded downstream, so this kills the write
		rtSel = 5'd0;
		rtNeg = 1'b0;
	end
	else
	begin
		rtSel = instr.Rt.num;
		rtNeg = instr.Rt.n;
	end

	// A write to r31 updates the stack pointer of the current mode
	Rt = fnMakeOperand(fnMapReg(rtSel, om), rtNeg);
end

endmodule

//--- src/decodeStage.sv
// Register-operand decode stage, one instruction per cycle
// result follows an inValid strobe by exactly one clock, no stall path
// Fields other than valid are don't-care while result.valid is low
// om and immPostfix must be stable alongside instr

`timescale 1ns/10ps

module decodeStage import quplsDecodePkg::*;
(
	input logic clk,
	input logic rstN,
	input logic inValid,
	input instr_t instr,
	input operating_mode_t om,
	input logic immPostfix,
	output decodeOut_t result
);

logic hasImmb;
logic hasImmc;
regOperand_t raOp;
regOperand_t rbOp;
regOperand_t rcOp;
regOperand_t rtOp;
decodeOut_t nextRec;

// ========================================
// Combinational decoders
// ========================================

decodeImm uImm
(
	.instr(instr),
	.immPostfix(immPostfix),
	.hasImmb(hasImmb),
	.hasImmc(hasImmc)
);

decodeRab uRab
(
	.instr(instr),
	.om(om),
	.hasImmb(hasImmb),
	.Ra(raOp),
	.Rb(rbOp)
);

decodeRc uRc
(
	.instr(instr),
	.om(om),
	.hasImmc(hasImmc),
	.Rc(rcOp)
);

decodeRt uRt
(
	.instr(instr),
	.om(om),
	.Rt(rtOp)
);

// ========================================
// Output register
// ========================================

// The record is loaded every cycle, valid alone says whether it counts
always_comb
begin
	nextRec.valid = inValid;
	nextRec.Ra = raOp;
	nextRec.Rb = rbOp;
	nextRec.Rc = rcOp;
	nextRec.Rt = rtOp;
	nextRec.hasImmb = hasImmb;
	nextRec.hasImmc = hasImmc;
end

always_ff @(posedge clk or negedge rstN)
begin
	if (!rstN)
		result <= '0;
	else
		result <= nextRec;
end

// ========================================
// Checks on the registered record
// ========================================

function automatic logic zeroOk(regOperand_t op);
	return !op.zero || (op.num == '0);
endfunction

// Highest legal number is the machine-mode stack pointer
function automatic logic rangeOk(regOperand_t op);
	return op.num <= (SP_BASE + 9'd3);
endfunction

// First edge after reset release still shows the cleared record
validAfterReset: assert property (@(posedge clk) $rose(rstN) |-> !result.valid)
	else $error("decodeStage: valid high right after reset release");

zeroConsistent: assert property (@(posedge clk) disable iff (!rstN)
	result.valid |-> (zeroOk(result.Ra) && zeroOk(result.Rb)
		&& zeroOk(result.Rc) && zeroOk(result.Rt)))
	else $error("decodeStage: zero flag set on a nonzero register");

numberInRange: assert property (@(posedge clk) disable iff (!rstN)
	result.valid |-> (rangeOk(result.Ra) && rangeOk(result.Rb)
		&& rangeOk(result.Rc) && rangeOk(result.Rt)))
	else $error("decodeStage: operand number beyond the stack pointers");

endmodule

//--- src/quplsDecodePkg.sv
// Shared types, opcodes and helper functions for the operand decode stage
// Register 31 always names the stack pointer of the current operating mode
// Only the opcodes that change operand selection are listed here
// Every other opcode decodes as a plain three-source instruction

package quplsDecodePkg;

// ========================================
// Register and mode types
// ========================================

// Values 0 to 31 are general registers and 32 to 35 the per-mode stack pointers
typedef logic [8:0] aregno_t;

typedef enum logic [1:0]
{
	OM_USER       = 2'd0,
	OM_SUPERVISOR = 2'd1,
	OM_HYPERVISOR = 2'd2,
	OM_MACHINE    = 2'd3
} operating_mode_t;

// Register field inside the instruction word, negate flag on top
typedef struct packed
{
	logic n;
	logic [4:0] num;
} regField_t;

// Fixed 32-bit layout, the opcode sits in the low bits
typedef struct packed
{
	logic immc;
	regField_t Rc;
	regField_t Rb;
	regField_t Ra;
	regField_t Rt;
	logic [6:0] opcode;
} instr_t;

// ========================================
// Opcodes and register constants
// ========================================

localparam logic [6:0] OP_R2    = 7'h02;
localparam logic [6:0] OP_ADDI  = 7'h04;
localparam logic [6:0] OP_SHIFT = 7'h10;
localparam logic [6:0] OP_ADDSI = 7'h14;
localparam logic [6:0] OP_ANDSI = 7'h15;
localparam logic [6:0] OP_ORSI  = 7'h16;
localparam logic [6:0] OP_EORSI = 7'h17;
localparam logic [6:0] OP_LDx   = 7'h48;
localparam logic [6:0] OP_STx   = 7'h50;
localparam logic [6:0] OP_FSTx  = 7'h51;

// Register number that is redirected to the mode's stack pointer
localparam logic [4:0] SP_REG  = 5'd31;
localparam aregno_t    SP_BASE = 9'd32;

// One decoded operand, zero is set when num is register 0
typedef struct packed
{
	aregno_t num;
	logic zero;
	logic neg;
} regOperand_t;

typedef struct packed
{
	logic valid;
	regOperand_t Ra;
	regOperand_t Rb;
	regOperand_t Rc;
	regOperand_t Rt;
	logic hasImmb;
	logic hasImmc;
} decodeOut_t;

// ========================================
// Decode helpers
// ========================================

function automatic logic fnIsStore(logic [6:0] opcode);
	case (opcode)
	OP_STx, OP_FSTx: return 1'b1;
	default: return 1'b0;
	endcase
endfunction

// Short-immediate group, Rt doubles as the accumulate source
function automatic logic fnIsSiGroup(logic [6:0] opcode);
	case (opcode)
	OP_ADDSI, OP_ANDSI, OP_ORSI, OP_EORSI: return 1'b1;
	default: return 1'b0;
	endcase
endfunction

function automatic logic fnImmb(logic [6:0] opcode);
	return (opcode == OP_ADDI) || fnIsSiGroup(opcode);
endfunction

// The immc bit only means something for opcodes outside the fixed formats
function automatic logic fnImmc(instr_t ins);
	if (ins.opcode == OP_R2 || ins.opcode == OP_SHIFT)
		return 1'b0;
	if (fnIsStore(ins.opcode) || fnIsSiGroup(ins.opcode))
		return 1'b0;
	return ins.immc;
endfunction

function automatic aregno_t fnMapReg(logic [4:0] num, operating_mode_t om);
	if (num == SP_REG)
		return SP_BASE + aregno_t'(om);
	return aregno_t'(num);
endfunction

// Builds an operand record and derives its zero flag
function automatic regOperand_t fnMakeOperand(aregno_t num, logic neg);
	regOperand_t op;
	op.num = num;
	op.zero = (num == '0);
	op.neg = neg;
	return op;
endfunction

endpackage

//--- verif/decodeVectors.svh
// Directed operand-decode vectors for the decode stage testbench
// Included inside the testbench module, which provides addVec
// Expected zero flags follow from the expected numbers and are not listed

`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

localparam int NUM_VECTORS = 20;

// The columns are opcode, om, immPostfix and immc, then the Rt Ra Rb Rc fields
// as {n, num[4:0]}, then the expected Ra Rb Rc Rt as {neg, num[8:0]}
// and last the expected {hasImmb, hasImmc}
task automatic loadVectors();
	// Plain register formats keep every field including the neg flags
	addVec(OP_R2,    0, 0, 0, 'h01, 'h02, 'h23, 'h04, 'h002, 'h203, 'h004, 'h001, 'b00);
	addVec(OP_SHIFT, 1, 0, 0, 'h25, 'h06, 'h07, 'h28, 'h006, 'h007, 'h208, 'h205, 'b00);
	addVec(OP_ADDI,  0, 0, 0, 'h0a, 'h2b, 'h0c, 'h0d, 'h20b, 'h000, 'h00d, 'h00a, 'b10);
	// The short-immediate group reads Rc from the Rt field and ignores immc
	addVec(OP_ADDSI, 0, 0, 1, 'h2e, 'h0f, 'h10, 'h11, 'h00f, 'h000, 'h20e, 'h20e, 'b10);
	addVec(OP_ANDSI, 2, 0, 0, 'h12, 'h13, 'h14, 'h15, 'h013, 'h000, 'h012, 'h012, 'b10);
	addVec(OP_ORSI,  3, 0, 0, 'h1f, 'h01, 'h00, 'h00, 'h001, 'h000, 'h023, 'h023, 'b10);
	addVec(OP_EORSI, 1, 0, 0, 'h16, 'h17, 'h18, 'h19, 'h017, 'h000, 'h016, 'h016, 'b10);
	// Stores move the data register to Rc and drop the destination
	addVec(OP_STx,   0, 0, 1, 'h29, 'h1a, 'h1b, 'h1c, 'h01a, 'h01b, 'h209, 'h000, 'b00);
	addVec(OP_FSTx,  2, 0, 0, 'h1f, 'h1f, 'h03, 'h04, 'h022, 'h003, 'h022, 'h000, 'b00);
	// Register 31 in every slot, one line per mode
	addVec(OP_R2,    0, 0, 0, 'h1f, 'h1f, 'h1f, 'h1f, 'h020, 'h020, 'h020, 'h020, 'b00);
	addVec(OP_R2,    1, 0, 0, 'h1f, 'h1f, 'h1f, 'h1f, 'h021, 'h021, 'h021, 'h021, 'b00);
	addVec(OP_R2,    2, 0, 0, 'h1f, 'h3f, 'h1f, 'h1f, 'h222, 'h022, 'h022, 'h022, 'b00);
	addVec(OP_R2,    3, 0, 0, 'h3f, 'h1f, 'h1f, 'h1f, 'h023, 'h023, 'h023, 'h223, 'b00);
	// Register 0 sets the zero flag in every slot
	addVec(OP_R2,    0, 0, 0, 'h00, 'h00, 'h20, 'h00, 'h000, 'h200, 'h000, 'h000, 'b00);
	// Rc immediates from the immc bit and from a postfix
	addVec(OP_LDx,   0, 0, 1, 'h05, 'h06, 'h07, 'h28, 'h006, 'h007, 'h000, 'h005, 'b01);
	addVec(OP_LDx,   0, 0, 0, 'h05, 'h06, 'h07, 'h28, 'h006, 'h007, 'h208, 'h005, 'b00);
	addVec(OP_R2,    0, 0, 1, 'h01, 'h02, 'h03, 'h09, 'h002, 'h003, 'h009, 'h001, 'b00);
	addVec(OP_R2,    0, 1, 0, 'h01, 'h02, 'h03, 'h04, 'h002, 'h003, 'h000, 'h001, 'b01);
	addVec(OP_ADDI,  3, 1, 0, 'h1f, 'h02, 'h03, 'h04, 'h002, 'h000, 'h000, 'h023, 'b11);
	addVec(OP_LDx,   2, 0, 0, 'h0c, 'h1f, 'h2a, 'h0b, 'h022, 'h20a, 'h00b, 'h00c, 'b00);
endtask

`endif

//--- verif/decodeStageTb.sv
// Testbench for the register-operand decode stage
// Directed vectors come from decodeVectors.svh, then 200 seeded random cases
// Each record is sampled at the falling edge after the edge that captured it

`timescale 1ns/10ps

module decodeStageTb import quplsDecodePkg::*;
();

`include "decodeVectors.svh"

localparam int RANDOM_CASES = 200;
// Reset, table, random cases and some slack for the idle cycles
localparam int CYCLE_LIMIT = 5 + NUM_VECTORS + RANDOM_CASES + 20;
localparam logic [6:0] OPCODES [10] = '{OP_R2, OP_SHIFT, OP_ADDI, OP_ADDSI, OP_ANDSI,
	OP_ORSI, OP_EORSI, OP_STx, OP_FSTx, OP_LDx};

typedef struct packed
{
	logic v;
	instr_t ins;
	operating_mode_t om;
	logic post;
	decodeOut_t exp;
} vector_t;

logic clk = 1'b0;
logic rstN;
logic inValid;
instr_t instr;
operating_mode_t om;
logic immPostfix;
decodeOut_t result;

vector_t vectors[$];
int errors = 0;
int cycleCount = 0;
// Record expected at the next falling edge, the reset value comes first
decodeOut_t pendExp = '0;

decodeStage DUT
(
	.clk(clk),
	.rstN(rstN),
	.inValid(inValid),
	.instr(instr),
	.om(om),
	.immPostfix(immPostfix),
	.result(result)
);

always #20 clk = ~clk;

// Ends a stuck run once the cycle budget is used up
initial
begin
	while (cycleCount < CYCLE_LIMIT)
	begin
		@(posedge clk);
		cycleCount++;
	end
	$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
	$display("Test failed");
	$finish;
end

// ========================================
// Checking
// ========================================

task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
	begin
		errors++;
		$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
	end
endtask

task automatic checkOperand(input string name, input regOperand_t got, input regOperand_t exp);
	checkValue({"result.", name, ".num"}, 32'(got.num), 32'(exp.num));
	checkValue({"result.", name, ".zero"}, 32'(got.zero), 32'(exp.zero));
	checkValue({"result.", name, ".neg"}, 32'(got.neg), 32'(exp.neg));
endtask

// Operand fields are only meaningful on a valid record
task automatic checkRecord(input decodeOut_t got, input decodeOut_t exp);
	checkValue("result.valid", 32'(got.valid), 32'(exp.valid));
	if (exp.valid)
	begin
		checkOperand("Ra", got.Ra, exp.Ra);
		checkOperand("Rb", got.Rb, exp.Rb);
		checkOperand("Rc", got.Rc, exp.Rc);
		checkOperand("Rt", got.Rt, exp.Rt);
		checkValue("result.hasImmb", 32'(got.hasImmb), 32'(exp.hasImmb));
		checkValue("result.hasImmc", 32'(got.hasImmc), 32'(exp.hasImmc));
	end
endtask

// ========================================
// Reference model and table building
// ========================================

function automatic regOperand_t refOperand(logic [4:0] num, logic neg, operating_mode_t mode);
	regOperand_t op;
	op.num = (num == 5'd31) ? 9'd32 + 9'(mode) : 9'(num);
	op.zero = (op.num == 9'd0);
	op.neg = neg;
	return op;
endfunction

function automatic decodeOut_t refRecord(logic v, instr_t ins, operating_mode_t mode, logic post);
	decodeOut_t r;
	logic store;
	logic siGroup;
	logic defGroup;
	store = ins.opcode inside {OP_STx, OP_FSTx};
	siGroup = ins.opcode inside {OP_ADDSI, OP_ANDSI, OP_ORSI, OP_EORSI};
	defGroup = !(ins.opcode inside {OP_R2, OP_SHIFT}) && !store && !siGroup;
	r.valid = v;
	r.hasImmb = (ins.opcode == OP_ADDI) || siGroup;
	r.hasImmc = post || (defGroup && ins.immc);
	r.Ra = refOperand(ins.Ra.num, ins.Ra.n, mode);
	r.Rb = r.hasImmb ? refOperand(5'd0, 1'b0, mode) : refOperand(ins.Rb.num, ins.Rb.n, mode);
	if (r.hasImmc)
		r.Rc = refOperand(5'd0, 1'b0, mode);
	else if (siGroup || store)
		r.Rc = refOperand(ins.Rt.num, ins.Rt.n, mode);
	else
		r.Rc = refOperand(ins.Rc.num, ins.Rc.n, mode);
	r.Rt = store ? refOperand(5'd0, 1'b0, mode) : refOperand(ins.Rt.num, ins.Rt.n, mode);
	return r;
endfunction

// Table entries give {neg, num}, zero is set for register 0
function automatic regOperand_t expOperand(int e);
	regOperand_t op;
	op.num = e[8:0];
	op.neg = e[9];
	op.zero = (op.num == 9'd0);
	return op;
endfunction

task automatic addVec(input logic [6:0] op, input int mode, input int post, input int immc,
	input int rt, input int ra, input int rb, input int rc,
	input int eA, input int eB, input int eC, input int eT, input int eImm);
	vector_t vec;
	vec.v = 1'b1;
	vec.ins.opcode = op;
	vec.ins.Rt = regField_t'(rt[5:0]);
	vec.ins.Ra = regField_t'(ra[5:0]);
	vec.ins.Rb = regField_t'(rb[5:0]);
	vec.ins.Rc = regField_t'(rc[5:0]);
	vec.ins.immc = immc[0];
	vec.om = operating_mode_t'(mode[1:0]);
	vec.post = post[0];
	vec.exp.valid = 1'b1;
	vec.exp.Ra = expOperand(eA);
	vec.exp.Rb = expOperand(eB);
	vec.exp.Rc = expOperand(eC);
	vec.exp.Rt = expOperand(eT);
	vec.exp.hasImmb = eImm[1];
	vec.exp.hasImmc = eImm[0];
	vectors.push_back(vec);
endtask

// Drives one cycle and checks the record that was driven the cycle before
task automatic applyStep(input logic v, input instr_t ins, input operating_mode_t mode,
	input logic post, input decodeOut_t exp);
	@(posedge clk);
	inValid <= v;
	instr <= ins;
	om <= mode;
	immPostfix <= post;
	@(negedge clk);
	checkRecord(result, pendExp);
	pendExp = exp;
endtask

// ========================================
// Stimulus
// ========================================

initial
begin
	instr_t ins;
	operating_mode_t mode;
	logic v;
	logic post;
	void'($urandom(57948));
	rstN = 1'b0;
	inValid = 1'b0;
	instr = '0;
	om = OM_USER;
	immPostfix = 1'b0;
	loadVectors();
	repeat (5) @(posedge clk);
	rstN <= 1'b1;

	// Table entries go in back to back, then one strobe-free cycle
	foreach (vectors[i])
		applyStep(vectors[i].v, vectors[i].ins, vectors[i].om, vectors[i].post, vectors[i].exp);
	applyStep(1'b0, '0, OM_USER, 1'b0, '0);

	// Mostly listed opcodes so that every decode path sees random fields
	for (int n = 0; n < RANDOM_CASES; n++)
	begin
		v = ($urandom % 8) != 0;
		ins = instr_t'($urandom);
		if (($urandom % 4) != 0)
			ins.opcode = OPCODES[4'($urandom % 10)];
		mode = operating_mode_t'(2'($urandom % 4));
		post = ($urandom % 4) == 0;
		applyStep(v, ins, mode, post, refRecord(v, ins, mode, post));
	end
	applyStep(1'b0, '0, OM_USER, 1'b0, '0);

	$display("Run complete with %0d errors after %0d cycles", errors, cycleCount);
	if (errors == 0)
		$display("Test passed");
	else
		$display("Test failed");
	$finish;
end

endmodule
